// File: dv/execute_memory_core_assertions.sv
`timescale 1ns/1ps

module execute_memory_core_assertions (
	input logic                        i_clk,
	input logic                        i_reset,
	input logic                        i_wb_cyc,
	input logic                        i_wb_stb,
	input logic                        i_wb_ack,
	input logic [rv_pkg::WB_ADR_W-1:0] i_wb_adr,
	input logic [rv_pkg::XLEN-1:0]     i_wb_dat,
	input logic                        i_stall
);

	// Cycle ends right after the slave answers
	a_drop_after_ack: assert property (@(posedge i_clk) disable iff (!i_reset)
		i_wb_ack |=> (!i_wb_cyc && !i_wb_stb))
		else $error("Wishbone cycle held past ack");

	// Master must hold the request until the slave answers
	a_req_stable: assert property (@(posedge i_clk) disable iff (!i_reset)
		(i_wb_stb && !i_wb_ack) |=> ($stable(i_wb_adr) && $stable(i_wb_dat)))
		else $error("Wishbone address or data changed during wait");

	a_ack_in_stb: assert property (@(posedge i_clk) disable iff (!i_reset)
		i_wb_ack |-> i_wb_stb)
		else $error("Wishbone ack outside a strobe");

	a_no_stall_after_reset: assert property (@(posedge i_clk)
		$rose(i_reset) |-> !i_stall)
		else $error("Stall high right after reset release");

endmodule

bind execute_memory_core execute_memory_core_assertions u_assertions (
	.i_clk (i_clk), .i_reset (i_reset),
	.i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_ack (wb_ack),
	.i_wb_adr (wb_adr), .i_wb_dat (wb_dat_w), .i_stall (stall)
);

// File: dv/tb_execute_memory_core.sv
`timescale 1ns/1ps

module tb_execute_memory_core;

	import rv_pkg::*;

	logic                  i_clk = 1'b0;
	logic                  i_reset = 1'b0;
	logic                  i_insn_vld = 1'b0;
	logic [XLEN-1:0]       i_pc = '0;
	logic [XLEN-1:0]       i_pc_four = '0;
	logic [ALU_OP_W-1:0]   i_alu_op = '0;
	logic [XLEN-1:0]       i_rs1_data = '0;
	logic [XLEN-1:0]       i_operand_b = '0;
	logic [XLEN-1:0]       i_rs2_data = '0;
	logic [REG_ADDR_W-1:0] i_rd_addr = '0;
	logic                  i_rd_wren = 1'b0;
	logic                  i_mem_wren = 1'b0;
	logic                  i_mem_rden = 1'b0;
	logic [WB_SEL_W-1:0]   i_wb_sel = '0;
	logic [SIZE_W-1:0]     i_bmask = '0;
	logic [EXT_W-1:0]      i_sl_sel = '0;
	logic                  o_stall;
	logic                  o_rd_wren;
	logic [REG_ADDR_W-1:0] o_rd_addr;
	logic [XLEN-1:0]       o_rd_data;
	logic                  o_retire_vld;

	integer seed = 32'h71da;
	int errors = 0;
	int cycle_cnt = 0;
	logic [XLEN-1:0] model_mem [DMEM_WORDS];
	logic exp_wren [$];
	logic [REG_ADDR_W-1:0] exp_addr [$];
	logic [XLEN-1:0] exp_data [$];
	int exp_cycle [$];

	execute_memory_core dut (.*);

	always #50 i_clk = ~i_clk;

	task automatic check_word(input string name, input logic [XLEN-1:0] got, exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg_addr(input string name, input logic [REG_ADDR_W-1:0] got, exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		errors++;
	endtask

	function automatic logic [XLEN-1:0] alu_model(input logic [ALU_OP_W-1:0] op,
		input logic [XLEN-1:0] a, b);
		case (op)
			ALU_ADD:   return a + b;
			ALU_SUB:   return a - b;
			ALU_AND:   return a & b;
			ALU_OR:    return a | b;
			ALU_XOR:   return a ^ b;
			ALU_SLL:   return a << b[4:0];
			ALU_SRL:   return a >> b[4:0];
			ALU_SRA:   return $signed(a) >>> b[4:0];
			ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
			ALU_PASSB: return b;
			default:   return '0;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] load_model(input logic [XLEN-1:0] addr,
		input logic [SIZE_W-1:0] size, input logic [EXT_W-1:0] ext);
		logic [XLEN-1:0] w;
		logic [7:0] b;
		logic [15:0] h;
		w = model_mem[addr[DMEM_ADDR_W+1:2]];
		b = w[8*addr[1:0] +: 8];
		h = addr[1] ? w[31:16] : w[15:0];
		if (size == SIZE_BYTE)
			return (ext == EXT_UNSIGNED) ? {24'd0, b} : {{24{b[7]}}, b};
		if (size == SIZE_HALF)
			return (ext == EXT_UNSIGNED) ? {16'd0, h} : {{16{h[15]}}, h};
		return w;
	endfunction

	task automatic store_model(input logic [XLEN-1:0] addr, input logic [SIZE_W-1:0] size,
		input logic [XLEN-1:0] data);
		if (size == SIZE_BYTE)
			model_mem[addr[DMEM_ADDR_W+1:2]][8*addr[1:0] +: 8] = data[7:0];
		else if (size == SIZE_HALF)
			model_mem[addr[DMEM_ADDR_W+1:2]][16*addr[1] +: 16] = data[15:0];
		else
			model_mem[addr[DMEM_ADDR_W+1:2]] = data;
	endtask

	// Called at 1 ns after a rising edge; returns 1 ns after the accepting edge
	task automatic issue_insn(input logic [ALU_OP_W-1:0] op, input logic [XLEN-1:0] a, b, st,
		input logic [REG_ADDR_W-1:0] rd, input logic wren, mwr, mrd,
		input logic [WB_SEL_W-1:0] wsel, input logic [SIZE_W-1:0] size,
		input logic [EXT_W-1:0] ext);
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] res;
		int n;
		pc = $random(seed);
		pc[1:0] = 2'b00;
		n = 0;
		i_insn_vld = 1'b1;
		i_pc = pc;
		i_pc_four = pc + 4;
		i_alu_op = op;
		i_rs1_data = a;
		i_operand_b = b;
		i_rs2_data = st;
		i_rd_addr = rd;
		i_rd_wren = wren;
		i_mem_wren = mwr;
		i_mem_rden = mrd;
		i_wb_sel = wsel;
		i_bmask = size;
		i_sl_sel = ext;
		while (o_stall && n < 50) begin
			@(posedge i_clk);
			#1;
			n++;
		end
		if (o_stall)
			report_timeout("stall release");
		res = alu_model(op, a, b);
		if (wsel == WB_PC4)
			res = pc + 4;
		else if (wsel == WB_MEM)
			res = load_model(alu_model(op, a, b), size, ext);
		if (mwr)
			store_model(alu_model(op, a, b), size, st);
		@(posedge i_clk);
		#1;
		i_insn_vld = 1'b0;
		exp_wren.push_back(wren);
		exp_addr.push_back(rd);
		exp_data.push_back(res);
		exp_cycle.push_back((mwr || mrd) ? -1 : cycle_cnt);
	endtask

	task automatic wait_retire();
		int n;
		n = 0;
		while (exp_wren.size() != 0 && n < 50) begin
			@(posedge i_clk);
			#1;
			n++;
		end
		if (exp_wren.size() != 0)
			report_timeout("instruction retirement");
	endtask

	// Each retirement is matched against the oldest outstanding instruction
	always @(posedge i_clk) begin
		cycle_cnt++;
		if (o_retire_vld) begin
			if (exp_wren.size() == 0) begin
				$display("Instruction retired with none outstanding");
				errors++;
			end else begin
				check_bit("o_rd_wren", o_rd_wren, exp_wren[0]);
				if (exp_wren[0]) begin
					check_reg_addr("o_rd_addr", o_rd_addr, exp_addr[0]);
					check_word("o_rd_data", o_rd_data, exp_data[0]);
				end
				if (exp_cycle[0] >= 0 && exp_cycle[0] + 2 != cycle_cnt) begin
					$display("Instruction retired in cycle %0d instead of %0d",
						cycle_cnt, exp_cycle[0] + 2);
					errors++;
				end
				void'(exp_wren.pop_front());
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				void'(exp_cycle.pop_front());
			end
		end
	end

	task automatic report_test(input string name, input int start_errors);
		$display("%s: %s", name, (errors == start_errors) ? "passed" : "FAILED");
	endtask

	task automatic test_alu();
		int e;
		e = errors;
		for (int op = 0; op <= ALU_PASSB; op++) begin
			issue_insn(op, $random(seed), $random(seed), 0, op + 1, 1, 0, 0, WB_ALU,
				SIZE_WORD, EXT_SIGNED);
			wait_retire();
		end
		report_test("alu operations", e);
	endtask

	task automatic test_back_to_back();
		int e;
		e = errors;
		for (int i = 0; i < 5; i++)
			issue_insn(ALU_ADD, $random(seed), $random(seed), 0, 10 + i, 1, 0, 0, WB_ALU,
				SIZE_WORD, EXT_SIGNED);
		wait_retire();
		report_test("back to back", e);
	endtask

	task automatic test_word_mem();
		int e;
		logic [XLEN-1:0] addr;
		e = errors;
		addr = $random(seed) & 32'h3fc;
		issue_insn(ALU_ADD, addr, 0, $random(seed), 0, 0, 1, 0, WB_ALU, SIZE_WORD, EXT_SIGNED);
		issue_insn(ALU_ADD, addr, 0, 0, 7, 1, 0, 1, WB_MEM, SIZE_WORD, EXT_SIGNED);
		wait_retire();
		report_test("word store and load", e);
	endtask

	task automatic test_sub_word();
		int e;
		logic [XLEN-1:0] base;
		e = errors;
		base = $random(seed) & 32'h3fc;
		for (int off = 0; off < 4; off++)
			issue_insn(ALU_ADD, base, off, $random(seed), 0, 0, 1, 0, WB_ALU, SIZE_BYTE, 0);
		for (int off = 0; off < 4; off++) begin
			issue_insn(ALU_ADD, base, off, 0, 8, 1, 0, 1, WB_MEM, SIZE_BYTE, EXT_SIGNED);
			issue_insn(ALU_ADD, base, off, 0, 9, 1, 0, 1, WB_MEM, SIZE_BYTE, EXT_UNSIGNED);
		end
		issue_insn(ALU_ADD, base, 0, 0, 3, 1, 0, 1, WB_MEM, SIZE_WORD, EXT_SIGNED);
		for (int off = 0; off < 4; off += 2)
			issue_insn(ALU_ADD, base, off, $random(seed), 0, 0, 1, 0, WB_ALU, SIZE_HALF, 0);
		for (int off = 0; off < 4; off += 2) begin
			issue_insn(ALU_ADD, base, off, 0, 4, 1, 0, 1, WB_MEM, SIZE_HALF, EXT_SIGNED);
			issue_insn(ALU_ADD, base, off, 0, 5, 1, 0, 1, WB_MEM, SIZE_HALF, EXT_UNSIGNED);
		end
		issue_insn(ALU_ADD, base, 0, 0, 6, 1, 0, 1, WB_MEM, SIZE_WORD, EXT_SIGNED);
		wait_retire();
		report_test("byte and half accesses", e);
	endtask

	task automatic test_wb_select();
		int e;
		e = errors;
		issue_insn(ALU_ADD, $random(seed), $random(seed), 0, 1, 1, 0, 0, WB_PC4, SIZE_WORD, 0);
		issue_insn(ALU_XOR, $random(seed), $random(seed), 0, 2, 0, 0, 0, WB_ALU, SIZE_WORD, 0);
		wait_retire();
		report_test("writeback select", e);
	endtask

	task automatic test_stall_hold();
		int e;
		logic [XLEN-1:0] addr;
		e = errors;
		addr = $random(seed) & 32'h3fc;
		issue_insn(ALU_ADD, addr, 0, 0, 11, 1, 0, 1, WB_MEM, SIZE_WORD, EXT_SIGNED);
		check_bit("o_stall", o_stall, 1'b1);
		issue_insn(ALU_SUB, $random(seed), $random(seed), 0, 12, 1, 0, 0, WB_ALU, SIZE_WORD, 0);
		wait_retire();
		report_test("stall hold", e);
	endtask

	initial begin
		for (int i = 0; i < DMEM_WORDS; i++)
			model_mem[i] = '0;
		repeat (16) @(posedge i_clk);
		#1;
		i_reset = 1'b1;
		@(posedge i_clk);
		#1;
		test_alu();
		test_back_to_back();
		test_word_mem();
		test_sub_word();
		test_wb_select();
		test_stall_hold();
		finish_run();
	end

endmodule

// File: execute_memory_core.f
hdl/rv_pkg.sv
hdl/execute_stage.sv
hdl/flip_flop_execute_memory.sv
hdl/load_store_unit.sv
hdl/data_memory.sv
hdl/memory_writeback_stage.sv
hdl/execute_memory_core.sv
dv/execute_memory_core_assertions.sv
dv/tb_execute_memory_core.sv

// File: hdl/data_memory.sv
`timescale 1ns/1ps

module data_memory (
	input  logic                            i_clk,
	input  logic                            i_reset,
	input  logic                            i_wb_cyc,
	input  logic                            i_wb_stb,
	input  logic                            i_wb_we,
	input  logic [rv_pkg::WB_ADR_W-1:0]     i_wb_adr,
	input  logic [rv_pkg::XLEN-1:0]         i_wb_dat,
	input  logic [rv_pkg::WB_SEL_LANES-1:0] i_wb_sel,
	output logic [rv_pkg::XLEN-1:0]         o_wb_dat,
	output logic                            o_wb_ack
);

	import rv_pkg::*;

	logic [XLEN-1:0]        mem [DMEM_WORDS] = '{default: '0};
	logic [DMEM_ADDR_W-1:0] idx;
	logic                   ack_q;

	// Upper address bits alias onto the RAM
	assign idx = i_wb_adr[DMEM_ADDR_W-1:0];

	// One wait state, ack in the second strobe cycle
	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset)
			ack_q <= 1'b0;
		else
			ack_q <= i_wb_cyc && i_wb_stb && !ack_q;
	end

	always_ff @(posedge i_clk) begin
		if (i_wb_cyc && i_wb_stb && i_wb_we && ack_q) begin
			for (int i = 0; i < WB_SEL_LANES; i++) begin
				if (i_wb_sel[i])
					mem[idx][8*i +: 8] <= i_wb_dat[8*i +: 8];
			end
		end
		o_wb_dat <= mem[idx];
	end

	assign o_wb_ack = ack_q;

endmodule

// File: hdl/execute_memory_core.sv
`timescale 1ns/1ps

module execute_memory_core (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  logic                          i_insn_vld,
	input  logic [rv_pkg::XLEN-1:0]       i_pc,
	input  logic [rv_pkg::XLEN-1:0]       i_pc_four,
	input  logic [rv_pkg::ALU_OP_W-1:0]   i_alu_op,
	input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
	input  logic [rv_pkg::XLEN-1:0]       i_operand_b,
	input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
	input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
	input  logic                          i_rd_wren,
	input  logic                          i_mem_wren,
	input  logic                          i_mem_rden,
	input  logic [rv_pkg::WB_SEL_W-1:0]   i_wb_sel,
	input  logic [rv_pkg::SIZE_W-1:0]     i_bmask,
	input  logic [rv_pkg::EXT_W-1:0]      i_sl_sel,
	output logic                          o_stall,
	output logic                          o_rd_wren,
	output logic [rv_pkg::REG_ADDR_W-1:0] o_rd_addr,
	output logic [rv_pkg::XLEN-1:0]       o_rd_data,
	output logic                          o_retire_vld
);

	import rv_pkg::*;

	logic [XLEN-1:0]         alu_data;
	logic [XLEN-1:0]         pc_four_m, alu_data_m, rs2_data_m, load_data;
	logic                    rd_wren_m, insn_vld_m, mem_wren_m, mem_rden_m;
	logic [WB_SEL_W-1:0]     wb_sel_m;
	logic [EXT_W-1:0]        sl_sel_m;
	logic [SIZE_W-1:0]       bmask_m;
	logic [REG_ADDR_W-1:0]   rd_addr_m;
	logic                    stall;
	logic                    wb_cyc, wb_stb, wb_we, wb_ack;
	logic [WB_ADR_W-1:0]     wb_adr;
	logic [XLEN-1:0]         wb_dat_w, wb_dat_r;
	logic [WB_SEL_LANES-1:0] wb_sel_lanes;

	execute_stage u_execute (
		.i_alu_op    (i_alu_op),
		.i_rs1_data  (i_rs1_data),
		.i_operand_b (i_operand_b),
		.o_alu_data  (alu_data)
	);

	// pc itself has no consumer past execute in this subsystem
	flip_flop_execute_memory u_ex_mem (
		.i_clk (i_clk), .i_reset (i_reset), .i_hold (stall),
		.i_pc_execute (i_pc), .i_pc_four_execute (i_pc_four),
		.i_rd_wren_execute (i_rd_wren), .i_insn_vld_execute (i_insn_vld),
		.i_mem_wren_execute (i_mem_wren), .i_mem_rden_execute (i_mem_rden),
		.i_wb_sel_execute (i_wb_sel), .i_sl_sel_execute (i_sl_sel),
		.i_bmask_execute (i_bmask), .i_alu_data_execute (alu_data),
		.i_rd_addr_execute (i_rd_addr), .i_rs2_data_execute (i_rs2_data),
		.o_pc_memory (), .o_pc_four_memory (pc_four_m),
		.o_rd_wren_memory (rd_wren_m), .o_insn_vld_memory (insn_vld_m),
		.o_mem_wren_memory (mem_wren_m), .o_mem_rden_memory (mem_rden_m),
		.o_wb_sel_memory (wb_sel_m), .o_sl_sel_memory (sl_sel_m),
		.o_bmask_memory (bmask_m), .o_alu_data_memory (alu_data_m),
		.o_rd_addr_memory (rd_addr_m), .o_rs2_data_memory (rs2_data_m)
	);

	load_store_unit u_lsu (
		.i_clk (i_clk), .i_reset (i_reset),
		.i_insn_vld (insn_vld_m), .i_mem_wren (mem_wren_m), .i_mem_rden (mem_rden_m),
		.i_addr (alu_data_m), .i_store_data (rs2_data_m),
		.i_bmask (bmask_m), .i_sl_sel (sl_sel_m),
		.o_load_data (load_data), .o_stall (stall),
		.o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_we (wb_we),
		.o_wb_adr (wb_adr), .o_wb_dat (wb_dat_w), .o_wb_sel (wb_sel_lanes),
		.i_wb_dat (wb_dat_r), .i_wb_ack (wb_ack)
	);

	data_memory u_dmem (
		.i_clk (i_clk), .i_reset (i_reset),
		.i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_we (wb_we),
		.i_wb_adr (wb_adr), .i_wb_dat (wb_dat_w), .i_wb_sel (wb_sel_lanes),
		.o_wb_dat (wb_dat_r), .o_wb_ack (wb_ack)
	);

	memory_writeback_stage u_mem_wb (
		.i_clk (i_clk), .i_reset (i_reset), .i_stall (stall),
		.i_insn_vld (insn_vld_m), .i_rd_wren (rd_wren_m), .i_rd_addr (rd_addr_m),
		.i_wb_sel (wb_sel_m), .i_alu_data (alu_data_m),
		.i_load_data (load_data), .i_pc_four (pc_four_m),
		.o_rd_wren (o_rd_wren), .o_rd_addr (o_rd_addr),
		.o_rd_data (o_rd_data), .o_retire_vld (o_retire_vld)
	);

	assign o_stall = stall;

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic [rv_pkg::ALU_OP_W-1:0] i_alu_op,
	input  logic [rv_pkg::XLEN-1:0]     i_rs1_data,
	input  logic [rv_pkg::XLEN-1:0]     i_operand_b,
	output logic [rv_pkg::XLEN-1:0]     o_alu_data
);

	import rv_pkg::*;

	logic [4:0]      shamt;
	logic [XLEN:0]   diff;
	logic            lt_signed;

	assign shamt = i_operand_b[4:0];

	// Shared subtractor, borrow gives the unsigned compare
	assign diff = {1'b0, i_rs1_data} - {1'b0, i_operand_b};

	// Signs differ: the negative one is smaller
	assign lt_signed = (i_rs1_data[XLEN-1] != i_operand_b[XLEN-1]) ?
		i_rs1_data[XLEN-1] : diff[XLEN-1];

	always_comb begin
		case (i_alu_op)
			ALU_ADD: begin
				o_alu_data = i_rs1_data + i_operand_b;
			end
			ALU_SUB: begin
				o_alu_data = diff[XLEN-1:0];
			end
			ALU_AND: begin
				o_alu_data = i_rs1_data & i_operand_b;
			end
			ALU_OR: begin
				o_alu_data = i_rs1_data | i_operand_b;
			end
			ALU_XOR: begin
				o_alu_data = i_rs1_data ^ i_operand_b;
			end
			ALU_SLL: begin
				o_alu_data = i_rs1_data << shamt;
			end
			ALU_SRL: begin
				o_alu_data = i_rs1_data >> shamt;
			end
			ALU_SRA: begin
				o_alu_data = $signed(i_rs1_data) >>> shamt;
			end
			ALU_SLT: begin
				o_alu_data = {{(XLEN-1){1'b0}}, lt_signed};
			end
			ALU_SLTU: begin
				o_alu_data = {{(XLEN-1){1'b0}}, diff[XLEN]};
			end
			ALU_PASSB: begin
				o_alu_data = i_operand_b;
			end
			default: begin
				o_alu_data = '0;
			end
		endcase
	end

endmodule

// File: hdl/flip_flop_execute_memory.sv
`timescale 1ns/1ps

module flip_flop_execute_memory (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  logic                          i_hold,
	input  logic [rv_pkg::XLEN-1:0]       i_pc_execute,
	input  logic [rv_pkg::XLEN-1:0]       i_pc_four_execute,
	input  logic                          i_rd_wren_execute,
	input  logic                          i_insn_vld_execute,
	input  logic                          i_mem_wren_execute,
	input  logic                          i_mem_rden_execute,
	input  logic [rv_pkg::WB_SEL_W-1:0]   i_wb_sel_execute,
	input  logic [rv_pkg::EXT_W-1:0]      i_sl_sel_execute,
	input  logic [rv_pkg::SIZE_W-1:0]     i_bmask_execute,
	input  logic [rv_pkg::XLEN-1:0]       i_alu_data_execute,
	input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr_execute,
	input  logic [rv_pkg::XLEN-1:0]       i_rs2_data_execute,

	output logic [rv_pkg::XLEN-1:0]       o_pc_memory,
	output logic [rv_pkg::XLEN-1:0]       o_pc_four_memory,
	output logic                          o_rd_wren_memory,
	output logic                          o_insn_vld_memory,
	output logic                          o_mem_wren_memory,
	output logic                          o_mem_rden_memory,
	output logic [rv_pkg::WB_SEL_W-1:0]   o_wb_sel_memory,
	output logic [rv_pkg::EXT_W-1:0]      o_sl_sel_memory,
	output logic [rv_pkg::SIZE_W-1:0]     o_bmask_memory,
	output logic [rv_pkg::XLEN-1:0]       o_alu_data_memory,
	output logic [rv_pkg::REG_ADDR_W-1:0] o_rd_addr_memory,
	output logic [rv_pkg::XLEN-1:0]       o_rs2_data_memory
);

	// Hold freezes the whole stage while the bus cycle is outstanding
	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			o_pc_memory       <= '0;
			o_pc_four_memory  <= '0;
			o_rd_wren_memory  <= 1'b0;
			o_insn_vld_memory <= 1'b0;
			o_mem_wren_memory <= 1'b0;
			o_mem_rden_memory <= 1'b0;
			o_wb_sel_memory   <= '0;
			o_sl_sel_memory   <= '0;
			o_bmask_memory    <= '0;
			o_alu_data_memory <= '0;
			o_rd_addr_memory  <= '0;
			o_rs2_data_memory <= '0;
		end else if (!i_hold) begin
			o_pc_memory       <= i_pc_execute;
			o_pc_four_memory  <= i_pc_four_execute;
			o_rd_wren_memory  <= i_rd_wren_execute;
			o_insn_vld_memory <= i_insn_vld_execute;
			o_mem_wren_memory <= i_mem_wren_execute;
			o_mem_rden_memory <= i_mem_rden_execute;
			o_wb_sel_memory   <= i_wb_sel_execute;
			o_sl_sel_memory   <= i_sl_sel_execute;
			o_bmask_memory    <= i_bmask_execute;
			o_alu_data_memory <= i_alu_data_execute;
			o_rd_addr_memory  <= i_rd_addr_execute;
			o_rs2_data_memory <= i_rs2_data_execute;
		end
	end

endmodule

// File: hdl/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
	input  logic                            i_clk,
	input  logic                            i_reset,
	input  logic                            i_insn_vld,
	input  logic                            i_mem_wren,
	input  logic                            i_mem_rden,
	input  logic [rv_pkg::XLEN-1:0]         i_addr,
	input  logic [rv_pkg::XLEN-1:0]         i_store_data,
	input  logic [rv_pkg::SIZE_W-1:0]       i_bmask,
	input  logic [rv_pkg::EXT_W-1:0]        i_sl_sel,
	output logic [rv_pkg::XLEN-1:0]         o_load_data,
	output logic                            o_stall,

	output logic                            o_wb_cyc,
	output logic                            o_wb_stb,
	output logic                            o_wb_we,
	output logic [rv_pkg::WB_ADR_W-1:0]     o_wb_adr,
	output logic [rv_pkg::XLEN-1:0]         o_wb_dat,
	output logic [rv_pkg::WB_SEL_LANES-1:0] o_wb_sel,
	input  logic [rv_pkg::XLEN-1:0]         i_wb_dat,
	input  logic                            i_wb_ack
);

	import rv_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_DONE} lsu_state_t;

	lsu_state_t      state;
	logic            mem_req;
	logic            bus_active;
	logic [XLEN-1:0] lane_data;
	logic [XLEN-1:0] load_ext;

	assign mem_req    = i_insn_vld && (i_mem_wren || i_mem_rden);
	assign bus_active = (state == ST_IDLE && mem_req) || state == ST_BUSY;

	// Done lets the held instruction leave without a second bus cycle
	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (mem_req)
						state <= i_wb_ack ? ST_DONE : ST_BUSY;
				end
				ST_BUSY: begin
					if (i_wb_ack)
						state <= ST_DONE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	assign o_stall  = mem_req && state != ST_DONE;
	assign o_wb_cyc = bus_active;
	assign o_wb_stb = bus_active;
	assign o_wb_we  = bus_active && i_mem_wren;
	assign o_wb_adr = i_addr[XLEN-1:2];

	// Replicate store data so any lane picks up the right bytes
	always_comb begin
		case (i_bmask)
			SIZE_BYTE: begin
				o_wb_dat = {4{i_store_data[7:0]}};
				o_wb_sel = 4'b0001 << i_addr[1:0];
			end
			SIZE_HALF: begin
				o_wb_dat = {2{i_store_data[15:0]}};
				o_wb_sel = i_addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				o_wb_dat = i_store_data;
				o_wb_sel = 4'b1111;
			end
		endcase
	end

	assign lane_data = i_wb_dat >> {i_addr[1:0], 3'b000};

	always_comb begin
		case (i_bmask)
			SIZE_BYTE: begin
				if (i_sl_sel == EXT_UNSIGNED)
					load_ext = {{(XLEN-8){1'b0}}, lane_data[7:0]};
				else
					load_ext = {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
			end
			SIZE_HALF: begin
				if (i_sl_sel == EXT_UNSIGNED)
					load_ext = {{(XLEN-16){1'b0}}, lane_data[15:0]};
				else
					load_ext = {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
			end
			default: begin
				load_ext = i_wb_dat;
			end
		endcase
	end

	// Load result held for the done cycle
	always_ff @(posedge i_clk) begin
		if (bus_active && i_wb_ack)
			o_load_data <= load_ext;
	end

endmodule

// File: hdl/memory_writeback_stage.sv
`timescale 1ns/1ps

module memory_writeback_stage (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  logic                          i_stall,
	input  logic                          i_insn_vld,
	input  logic                          i_rd_wren,
	input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
	input  logic [rv_pkg::WB_SEL_W-1:0]   i_wb_sel,
	input  logic [rv_pkg::XLEN-1:0]       i_alu_data,
	input  logic [rv_pkg::XLEN-1:0]       i_load_data,
	input  logic [rv_pkg::XLEN-1:0]       i_pc_four,
	output logic                          o_rd_wren,
	output logic [rv_pkg::REG_ADDR_W-1:0] o_rd_addr,
	output logic [rv_pkg::XLEN-1:0]       o_rd_data,
	output logic                          o_retire_vld
);

	import rv_pkg::*;

	logic            take;
	logic [XLEN-1:0] wb_data;

	// A stalled memory stage hands over a bubble
	assign take = i_insn_vld && !i_stall;

	always_comb begin
		case (i_wb_sel)
			WB_MEM:  wb_data = i_load_data;
			WB_PC4:  wb_data = i_pc_four;
			default: wb_data = i_alu_data;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			o_retire_vld <= 1'b0;
			o_rd_wren    <= 1'b0;
			o_rd_addr    <= '0;
			o_rd_data    <= '0;
		end else begin
			o_retire_vld <= take;
			o_rd_wren    <= take && i_rd_wren;
			o_rd_addr    <= i_rd_addr;
			o_rd_data    <= wb_data;
		end
	end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// ALU operation codes
	localparam int ALU_OP_W = 4;
	localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_PASSB = 4'd10;

	// Writeback source
	localparam int WB_SEL_W = 2;
	localparam logic [WB_SEL_W-1:0] WB_ALU = 2'd0;
	localparam logic [WB_SEL_W-1:0] WB_MEM = 2'd1;
	localparam logic [WB_SEL_W-1:0] WB_PC4 = 2'd2;

	// Access size, mask-shaped so byte lanes read naturally
	localparam int SIZE_W = 3;
	localparam logic [SIZE_W-1:0] SIZE_BYTE = 3'b001;
	localparam logic [SIZE_W-1:0] SIZE_HALF = 3'b011;
	localparam logic [SIZE_W-1:0] SIZE_WORD = 3'b111;

	// Load extension
	localparam int EXT_W = 3;
	localparam logic [EXT_W-1:0] EXT_SIGNED   = 3'd0;
	localparam logic [EXT_W-1:0] EXT_UNSIGNED = 3'd1;

	// Data RAM, addressed by word over Wishbone
	localparam int DMEM_WORDS  = 256;
	localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);
	localparam int WB_ADR_W    = XLEN - 2;
	localparam int WB_SEL_LANES = XLEN / 8;

endpackage

// File: run.sh
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f execute_memory_core.f \
	--top-module tb_execute_memory_core -o sim_tb > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0
